// File: design/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  instr_valid_i,
	input  rv_exec_pkg::instr_t   instr_i,
	output rv_exec_pkg::reg_addr_t rs1_addr_o,
	output rv_exec_pkg::reg_addr_t rs2_addr_o,
	output rv_exec_pkg::decoded_t dec_o
);
	import rv_exec_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_u;
	decoded_t   dec_d;

	logic       valid_q;
	logic       use_imm_q;
	logic       zero_a_q;
	logic       illegal_q;
	alu_op_e    alu_op_q;
	reg_addr_t  rd_q;
	reg_addr_t  rs1_q;
	reg_addr_t  rs2_q;
	word_t      imm_q;

	assign opcode = opcode_e'(instr_i[6:0]);
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_u  = {instr_i[31:12], 12'h000};

	// Regfile reads start now so data lines up with dec_o
	assign rs1_addr_o = instr_i[19:15];
	assign rs2_addr_o = instr_i[24:20];

	always_comb begin
		dec_d = '0;
		dec_d.valid = instr_valid_i;
		dec_d.rs1 = instr_i[19:15];
		dec_d.rs2 = instr_i[24:20];
		dec_d.rd = instr_i[11:7];
		case (funct3)
			3'b000: dec_d.alu_op = ALU_ADD;
			3'b001: dec_d.alu_op = ALU_SLL;
			3'b010: dec_d.alu_op = ALU_SLT;
			3'b011: dec_d.alu_op = ALU_SLTU;
			3'b100: dec_d.alu_op = ALU_XOR;
			3'b101: dec_d.alu_op = ALU_SRL;
			3'b110: dec_d.alu_op = ALU_OR;
			default: dec_d.alu_op = ALU_AND;
		endcase
		case (opcode)
			OPC_OP: begin
				if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					dec_d.alu_op = ALU_SUB;
				end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
					dec_d.alu_op = ALU_SRA;
				end else if (funct7 != 7'b0000000) begin
					dec_d.illegal = 1'b1;
				end
			end
			OPC_OP_IMM: begin
				dec_d.imm = imm_i;
				dec_d.use_imm = 1'b1;
				// Only the shifts constrain the upper immediate bits
				if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
					dec_d.alu_op = ALU_SRA;
				end else if (funct3[1:0] == 2'b01 && funct7 != 7'b0000000) begin
					dec_d.illegal = 1'b1;
				end
			end
			OPC_LUI: begin
				dec_d.imm = imm_u;
				dec_d.use_imm = 1'b1;
				dec_d.zero_a = 1'b1;
				dec_d.alu_op = ALU_ADD;
			end
			default: dec_d.illegal = 1'b1;
		endcase
		// Illegal encodings produce 0 + 0 with no destination
		if (dec_d.illegal) begin
			dec_d.imm = '0;
			dec_d.use_imm = 1'b1;
			dec_d.zero_a = 1'b1;
			dec_d.alu_op = ALU_ADD;
		end
		if (!instr_valid_i || dec_d.illegal) begin
			dec_d.rd = '0;
		end
		dec_d.illegal = dec_d.illegal && instr_valid_i;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q   <= 1'b0;
			use_imm_q <= 1'b0;
			zero_a_q  <= 1'b0;
			illegal_q <= 1'b0;
			alu_op_q  <= ALU_ADD;
			rd_q      <= '0;
		end else begin
			valid_q   <= dec_d.valid;
			use_imm_q <= dec_d.use_imm;
			zero_a_q  <= dec_d.zero_a;
			illegal_q <= dec_d.illegal;
			alu_op_q  <= dec_d.alu_op;
			rd_q      <= dec_d.rd;
		end
	end

	always_ff @(posedge clk) begin
		rs1_q <= dec_d.rs1;
		rs2_q <= dec_d.rs2;
		imm_q <= dec_d.imm;
	end

	assign dec_o = '{valid: valid_q, rs1: rs1_q, rs2: rs2_q, rd: rd_q, imm: imm_q,
		use_imm: use_imm_q, zero_a: zero_a_q, alu_op: alu_op_q, illegal: illegal_q};

	// Downstream write and bypass rely on rd alone
	a_illegal_no_rd: assert property (@(posedge clk) disable iff (!rst_n)
		dec_o.illegal |-> dec_o.rd == '0);

endmodule

// File: design/rv_exec_pkg.sv
package rv_exec_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	localparam int N_REGS     = 32;
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [31:0]           instr_t;

	// ========================================================================
	// Encodings
	// ========================================================================

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	// Major opcodes handled by the pipeline, all others are illegal
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111
	} opcode_e;

	// ========================================================================
	// Stage payloads
	// ========================================================================

	// Decode to execute
	typedef struct packed {
		logic      valid;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     imm;
		logic      use_imm;
		logic      zero_a;    // LUI and illegal encodings
		alu_op_e   alu_op;
		logic      illegal;
	} decoded_t;

	// Execute to writeback, also fed back for bypass
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     result;
		logic      illegal;
	} result_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     result;
		logic      illegal;
	} wb_t;

endpackage

// File: design/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid_i,
	input  rv_exec_pkg::instr_t instr_i,
	output rv_exec_pkg::wb_t    wb_o
);
	import rv_exec_pkg::*;

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t     rdata1;
	word_t     rdata2;
	decoded_t  dec;
	result_t   res;
	result_t   xw;
	result_t   wx;
	reg_addr_t rf_waddr;
	word_t     rf_wdata;
	logic      rf_wen;

	rv_decoder u_decoder (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.rs1_addr_o    (rs1_addr),
		.rs2_addr_o    (rs2_addr),
		.dec_o         (dec)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata),
		.wen_i    (rf_wen)
	);

	rv_execute u_execute (
		.clk      (clk),
		.rst_n    (rst_n),
		.dec_i    (dec),
		.rdata1_i (rdata1),
		.rdata2_i (rdata2),
		.xw_i     (xw),
		.wx_i     (wx),
		.res_o    (res)
	);

	rv_writeback u_writeback (
		.clk        (clk),
		.rst_n      (rst_n),
		.res_i      (res),
		.wb_o       (wb_o),
		.rf_waddr_o (rf_waddr),
		.rf_wdata_o (rf_wdata),
		.rf_wen_o   (rf_wen),
		.xw_o       (xw),
		.wx_o       (wx)
	);

endmodule

// File: design/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_exec_pkg::decoded_t dec_i,
	input  rv_exec_pkg::word_t    rdata1_i,
	input  rv_exec_pkg::word_t    rdata2_i,
	input  rv_exec_pkg::result_t  xw_i,
	input  rv_exec_pkg::result_t  wx_i,
	output rv_exec_pkg::result_t  res_o
);
	import rv_exec_pkg::*;

	word_t      op_a;
	word_t      op_b;
	logic [4:0] shamt;
	word_t      alu_y;

	logic       valid_q;
	logic       illegal_q;
	reg_addr_t  rd_q;
	word_t      result_q;

	// Newest value first: xw is one instruction ahead, wx two ahead
	function automatic word_t fwd_operand(
		input reg_addr_t idx,
		input word_t     rf_val,
		input result_t   xw,
		input result_t   wx
	);
		word_t val;
		if (idx == '0) begin
			val = '0;
		end else if (xw.rd == idx) begin
			val = xw.result;
		end else if (wx.rd == idx) begin
			val = wx.result;
		end else begin
			val = rf_val;
		end
		return val;
	endfunction

	// ========================================================================
	// Operand select and ALU
	// ========================================================================

	assign op_a  = dec_i.zero_a ? '0 : fwd_operand(dec_i.rs1, rdata1_i, xw_i, wx_i);
	assign op_b  = dec_i.use_imm ? dec_i.imm : fwd_operand(dec_i.rs2, rdata2_i, xw_i, wx_i);
	assign shamt = op_b[4:0];

	always_comb begin
		case (dec_i.alu_op)
			ALU_ADD:  alu_y = op_a + op_b;
			ALU_SUB:  alu_y = op_a - op_b;
			ALU_SLL:  alu_y = op_a << shamt;
			ALU_SLT:  alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_y = {{(XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR:  alu_y = op_a ^ op_b;
			ALU_SRL:  alu_y = op_a >> shamt;
			ALU_SRA:  alu_y = word_t'($signed(op_a) >>> shamt);
			ALU_OR:   alu_y = op_a | op_b;
			default:  alu_y = op_a & op_b;
		endcase
	end

	// ========================================================================
	// Result register
	// ========================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q   <= 1'b0;
			illegal_q <= 1'b0;
			rd_q      <= '0;
		end else begin
			valid_q   <= dec_i.valid;
			illegal_q <= dec_i.illegal;
			rd_q      <= dec_i.rd;
		end
	end

	always_ff @(posedge clk) begin
		result_q <= alu_y;
	end

	assign res_o = '{valid: valid_q, rd: rd_q, result: result_q, illegal: illegal_q};

	// Catches a bypass or regfile path that picked up undriven data
	a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
		res_o.valid |-> !$isunknown(res_o.result));

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
	input  logic                   clk,
	input  logic                   rst_n,
	input  rv_exec_pkg::reg_addr_t raddr1_i,
	input  rv_exec_pkg::reg_addr_t raddr2_i,
	output rv_exec_pkg::word_t     rdata1_o,
	output rv_exec_pkg::word_t     rdata2_o,
	input  rv_exec_pkg::reg_addr_t waddr_i,
	input  rv_exec_pkg::word_t     wdata_i,
	input  logic                   wen_i
);
	import rv_exec_pkg::*;

	word_t regs [N_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < N_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Registered reads, a write on the same edge is not seen
	always_ff @(posedge clk) begin
		rdata1_o <= regs[raddr1_i];
		rdata2_o <= regs[raddr2_i];
	end

	// x0 must stay zero, writeback filters rd == 0
	a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wen_i |-> waddr_i != '0);

endmodule

// File: design/rv_writeback.sv
`timescale 1ns/1ps

module rv_writeback (
	input  logic                   clk,
	input  logic                   rst_n,
	input  rv_exec_pkg::result_t   res_i,
	output rv_exec_pkg::wb_t       wb_o,
	output rv_exec_pkg::reg_addr_t rf_waddr_o,
	output rv_exec_pkg::word_t     rf_wdata_o,
	output logic                   rf_wen_o,
	output rv_exec_pkg::result_t   xw_o,
	output rv_exec_pkg::result_t   wx_o
);
	import rv_exec_pkg::*;

	logic      wx_valid_q;
	logic      wx_illegal_q;
	reg_addr_t wx_rd_q;
	word_t     wx_result_q;

	assign wb_o = '{valid: res_i.valid, rd: res_i.rd, result: res_i.result,
		illegal: res_i.illegal};

	// Bubbles and illegal ops already carry rd == 0
	assign rf_waddr_o = res_i.rd;
	assign rf_wdata_o = res_i.result;
	assign rf_wen_o   = |res_i.rd;

	assign xw_o = res_i;

	// Covers the edge where the regfile write and the next read coincide
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wx_valid_q   <= 1'b0;
			wx_illegal_q <= 1'b0;
			wx_rd_q      <= '0;
		end else begin
			wx_valid_q   <= res_i.valid;
			wx_illegal_q <= res_i.illegal;
			wx_rd_q      <= res_i.rd;
		end
	end

	always_ff @(posedge clk) begin
		wx_result_q <= res_i.result;
	end

	assign wx_o = '{valid: wx_valid_q, rd: wx_rd_q, result: wx_result_q,
		illegal: wx_illegal_q};

	a_illegal_wb_rd: assert property (@(posedge clk) disable iff (!rst_n)
		wb_o.valid && wb_o.illegal |-> wb_o.rd == '0);

endmodule

// File: dv/rv_exec_stim.txt
// Columns: group_valid_instr_rd_result_illegal (hex, underscores separate fields)
// Groups: 1 imm ops, 2 reg ops, 3 lui, 4 bypass, 5 x0, 6 illegal
1_1_FFB00093_01_FFFFFFFB_0
1_1_FFD0A113_02_00000001_0
1_1_0050B193_03_00000000_0
1_1_FFF0C213_04_00000004_0
1_1_F0026293_05_FFFFFF04_0
1_1_FF02F313_06_FFFFFF00_0
1_1_00409393_07_FFFFFFB0_0
1_1_01C0D413_08_0000000F_0
1_1_4010D493_09_FFFFFFFD_0
2_1_00808533_0A_0000000A_0
2_1_408085B3_0B_FFFFFFEC_0
2_1_00A41633_0C_00003C00_0
2_1_0080A6B3_0D_00000001_0
2_1_0080B733_0E_00000000_0
2_1_0080C7B3_0F_FFFFFFF4_0
2_1_00D5D833_10_7FFFFFF6_0
2_1_40D5D8B3_11_FFFFFFF6_0
2_1_00C56933_12_00003C0A_0
2_1_0067F9B3_13_FFFFFF00_0
3_1_ABCDEA37_14_ABCDE000_0
3_1_80000AB7_15_80000000_0
4_1_06400B13_16_00000064_0
4_1_016B0BB3_17_000000C8_0
4_1_416B8C33_18_00000064_0
4_1_017B4CB3_19_000000AC_0
4_0_00000000_00_00000000_0
4_1_FFFC8D13_1A_000000AB_0
4_0_00000000_00_00000000_0
4_0_00000000_00_00000000_0
4_1_018D0DB3_1B_0000010F_0
4_1_00100E13_1C_00000001_0
4_1_002E0E13_1C_00000003_0
4_1_004E0E13_1C_00000007_0
4_1_01CE0EB3_1D_0000000E_0
5_1_005B0013_00_00000069_0
5_1_00000F33_1E_00000000_0
5_1_01606FB3_1F_00000064_0
6_1_0FF0000F_00_00000000_1
6_1_300093F3_00_00000000_1
6_1_00102223_00_00000000_1
6_1_016E02B3_05_0000006B_0
6_1_00038413_08_FFFFFFB0_0

// File: dv/tb_rv_exec.sv
`timescale 1ns/1ps

module tb_rv_exec;
	import rv_exec_pkg::*;

	localparam int N_RECS      = 42;
	localparam int RST_CYCLES  = 2;
	localparam int TAIL_CYCLES = 3;
	localparam int MAX_CYCLES  = N_RECS + RST_CYCLES + 10;

	// One line of the stim file
	// Each flag takes a full hex digit
	typedef struct packed {
		logic [3:0] group;
		logic [3:0] valid;
		instr_t     instr;
		logic [7:0] rd;
		word_t      result;
		logic [3:0] illegal;
	} stim_rec_t;

	typedef struct packed {
		int unsigned idx;
		logic [3:0]  group;
		reg_addr_t   rd;
		word_t       result;
		logic        illegal;
	} expect_t;

	logic        clk;
	logic        rst_n;
	logic        instr_valid_i;
	instr_t      instr_i;
	wb_t         wb;

	logic [83:0] stim_mem [N_RECS];
	expect_t     exp_q [$];
	int          cycle_cnt = 0;

	rv_exec_top uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.wb_o          (wb)
	);

	always #2 clk = ~clk;

	// ========================================================================
	// Reporting helpers
	// ========================================================================

	function automatic string group_name(input logic [3:0] group);
		string name;
		case (group)
			4'd1:    name = "imm_ops";
			4'd2:    name = "reg_ops";
			4'd3:    name = "lui";
			4'd4:    name = "bypass";
			4'd5:    name = "x0";
			4'd6:    name = "illegal";
			default: name = "unknown";
		endcase
		return name;
	endfunction

	task automatic print_mismatch(input string test, input string field,
		input word_t expected, input word_t actual);
		$display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h",
			test, field, expected, actual);
		$display("ERRORS FOUND");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
	endtask

	// ========================================================================
	// Stimulus and checking
	// ========================================================================

	task automatic drive_record(input stim_rec_t rec, input int idx);
		expect_t entry;
		instr_valid_i <= rec.valid[0];
		instr_i       <= rec.instr;
		if (rec.valid[0]) begin
			entry.idx     = idx;
			entry.group   = rec.group;
			entry.rd      = rec.rd[4:0];
			entry.result  = rec.result;
			entry.illegal = rec.illegal[0];
			exp_q.push_back(entry);
		end
	endtask

	task automatic check_writeback(input wb_t got);
		expect_t front;
		string   test;
		assert (exp_q.size() != 0) else begin
			report_failure("Writeback valid while no instruction was pending");
			$fatal(1, "unexpected writeback");
		end
		front = exp_q.pop_front();
		test  = $sformatf("%s #%0d", group_name(front.group), front.idx);
		assert (got.rd == front.rd) else begin
			print_mismatch(test, "rd", word_t'(front.rd), word_t'(got.rd));
			$fatal(1, "rd mismatch");
		end
		assert (got.illegal == front.illegal) else begin
			print_mismatch(test, "illegal", word_t'(front.illegal), word_t'(got.illegal));
			$fatal(1, "illegal flag mismatch");
		end
		// Results without a destination are never visible
		if (front.rd != '0) begin
			assert (got.result == front.result) else begin
				print_mismatch(test, "result", front.result, got.result);
				$fatal(1, "result mismatch");
			end
		end
	endtask

	// Sample mid-cycle where wb_o has settled
	always @(negedge clk) begin
		if (rst_n && wb.valid) begin
			check_writeback(wb);
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			report_failure("Timeout before all writebacks arrived");
			$fatal(1, "timeout");
		end
	end

	initial begin
		clk = 1'b0;
		rst_n         <= 1'b0;
		instr_valid_i <= 1'b0;
		instr_i       <= '0;
		$readmemh("dv/rv_exec_stim.txt", stim_mem);
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < N_RECS; i++) begin
			@(posedge clk);
			drive_record(stim_rec_t'(stim_mem[i]), i);
		end
		@(posedge clk);
		instr_valid_i <= 1'b0;
		instr_i       <= '0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		// A few idle cycles expose a stray writeback after the last record
		repeat (TAIL_CYCLES) @(posedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_rv_exec \
	-f sources.f --Mdir obj_dir -o sim_tb_rv_exec \
	&& ./obj_dir/sim_tb_rv_exec \
	|| { echo "simulation failed"; exit 1; }

// File: sources.f
design/rv_exec_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_writeback.sv
design/rv_exec_top.sv
dv/tb_rv_exec.sv
